// File: verilog/c16_glue_pkg.sv
package c16_glue_pkg;

	// ----------------------------------------------------------------------
	// widths and memory map
	// ----------------------------------------------------------------------

	localparam int IOCTL_ADDR_W = 25;
	localparam int SDRAM_ADDR_W = 24;

	localparam logic [IOCTL_ADDR_W-1:0] ROM_MEM_START     = 25'h10000;
	localparam logic [IOCTL_ADDR_W-1:0] TAP_MEM_START     = 25'h20000;
	// index 0 images carry the 1541 ROM in the first 16k
	localparam logic [IOCTL_ADDR_W-1:0] KERNAL_ROM_OFFSET = 25'h04000;

	// download indices sent by the io controller
	localparam logic [7:0] IDX_ROM    = 8'h00;
	localparam logic [7:0] IDX_PRG    = 8'h01;
	localparam logic [7:0] IDX_KERNAL = 8'h03;
	localparam logic [7:0] IDX_TAP    = 8'h41;

	localparam int unsigned RESET_LONG_CYCLES  = 28_000_000;
	localparam int unsigned RESET_SHORT_CYCLES = 65_536;

	// basic end pointers patched after a prg injection
	localparam logic [15:0] ZP_END_PTR_ADDR [4] = '{16'h002d, 16'h002f, 16'h0031, 16'h009d};

	// bit positions in the menu status word
	localparam int STAT_REBOOT    = 0;
	localparam int STAT_MEM16K    = 4;
	localparam int STAT_OSD_RESET = 5;
	localparam int STAT_SID_LO    = 8;

	// ----------------------------------------------------------------------
	// bundles
	// ----------------------------------------------------------------------

	typedef struct packed {
		logic       memory_16k;
		logic       reboot;
		logic       osd_reset;
		logic [1:0] sid_type;
	} osd_cfg_t;

	typedef struct packed {
		logic        ras;
		logic        cas;
		logic        rw;
		logic [7:0]  a;
		logic [7:0]  dout;
		logic        basic_sel;
		logic        kernal_sel;
		logic [13:0] rom_addr;
		logic [3:0]  rom_sel;
	} c16_bus_t;

	typedef struct packed {
		logic                    downloading;
		logic [7:0]              index;
		logic                    wr;
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [7:0]              data;
	} ioctl_t;

	typedef struct packed {
		logic [SDRAM_ADDR_W-1:0] addr;
		logic [15:0]             din;
		logic                    we;
		logic                    oe;
		logic [1:0]              ds;
	} sdram_req_t;

	typedef struct packed {
		logic [13:0] addr;
		logic [7:0]  data;
		logic        kernal_wr;
		logic        basic_wr;
	} rom_dl_t;

	typedef enum logic [1:0] {
		NONE,
		ROM,
		PRG,
		TAP
	} dl_kind_t;

endpackage

// File: verilog/osd_config.sv
`timescale 1ns/1ns

module osd_config (
	input  logic                   clk28,
	input  logic                   pll_locked,
	input  logic [31:0]            status_i,
	input  logic                   button_reset_i,
	output c16_glue_pkg::osd_cfg_t cfg_o,
	output logic                   long_req_o,
	output logic                   short_req_o
);

	logic last_mem16k;

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			cfg_o       <= '0;
			last_mem16k <= 1'b0;
		end else begin
			cfg_o.reboot     <= status_i[c16_glue_pkg::STAT_REBOOT];
			cfg_o.memory_16k <= status_i[c16_glue_pkg::STAT_MEM16K];
			cfg_o.osd_reset  <= status_i[c16_glue_pkg::STAT_OSD_RESET];
			cfg_o.sid_type   <= status_i[c16_glue_pkg::STAT_SID_LO +: 2];
			last_mem16k      <= cfg_o.memory_16k;
		end
	end

	// io controller reboot asks for the long reset
	assign long_req_o = cfg_o.reboot;

	// a new memory map needs a fresh start of the core
	assign short_req_o = button_reset_i || cfg_o.osd_reset ||
		(cfg_o.memory_16k != last_mem16k);

endmodule

// File: verilog/reset_ctrl.sv
`timescale 1ns/1ns

module reset_ctrl #(
	parameter int unsigned LONG_CYCLES  = c16_glue_pkg::RESET_LONG_CYCLES,
	parameter int unsigned SHORT_CYCLES = c16_glue_pkg::RESET_SHORT_CYCLES
) (
	input  logic clk28,
	input  logic pll_locked,
	input  logic long_req_i,
	input  logic short_req_i,
	input  logic rom_download_i,
	output logic reset_o
);

	logic [31:0] reset_cnt;

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			// long reset on power up
			reset_cnt <= LONG_CYCLES;
		end else if (long_req_i) begin
			reset_cnt <= LONG_CYCLES;
		end else if (short_req_i || rom_download_i) begin
			// each rom byte keeps the core held until the image is complete
			reset_cnt <= SHORT_CYCLES;
		end else if (reset_cnt != 32'd0) begin
			reset_cnt <= reset_cnt - 32'd1;
		end
	end

	assign reset_o = (reset_cnt != 32'd0);

endmodule

// File: verilog/bus_phase.sv
`timescale 1ns/1ns

module bus_phase (
	input  logic                   clk28,
	input  c16_glue_pkg::c16_bus_t c16_bus_i,
	output logic                   clkref_o,
	output logic [15:0]            cpu_addr_o,
	output logic                   cas_wr_stb_o
);

	logic [3:0] clkdiv;
	logic       ras_d;
	logic       cas_d;
	logic       ras_fall;
	logic       cas_fall;

	assign ras_fall = ras_d && !c16_bus_i.ras;
	assign cas_fall = cas_d && !c16_bus_i.cas;

	// upper half of the divider is the c16 slot
	assign clkref_o = clkdiv[3];

	// slot divider restarts on every row strobe of the core
	always_ff @(posedge clk28) begin
		ras_d <= c16_bus_i.ras;
		cas_d <= c16_bus_i.cas;
		if (ras_fall) begin
			clkdiv <= 4'd0;
		end else begin
			clkdiv <= clkdiv + 4'd1;
		end
		// address is settled one cycle after the column strobe
		cas_wr_stb_o <= cas_fall;
	end

	// row address first, then column address on the multiplexed bus
	always_ff @(posedge clk28) begin
		if (ras_fall) begin
			cpu_addr_o[7:0] <= c16_bus_i.a;
		end
		if (cas_fall) begin
			cpu_addr_o[15:8] <= c16_bus_i.a;
		end
	end

	a_cas_in_ras: assert property (@(posedge clk28) cas_fall |-> !c16_bus_i.ras)
		else $error("column strobe fell outside a row cycle");

endmodule

// File: verilog/download_injector.sv
`timescale 1ns/1ns

module download_injector (
	input  logic                                  clk28,
	input  c16_glue_pkg::ioctl_t                  ioctl_i,
	input  logic                                  clkref_i,
	output c16_glue_pkg::dl_kind_t                dl_kind_o,
	output logic                                  io_wr_o,
	output logic [c16_glue_pkg::IOCTL_ADDR_W-1:0] io_wr_addr_o,
	output logic [7:0]                            io_wr_data_o,
	output logic                                  prg_done_o,
	output logic                                  rom_download_o,
	output c16_glue_pkg::rom_dl_t                 rom_dl_o,
	output logic                                  c16_wait_o
);

	logic       last_clkref;
	logic       slot_fall;
	logic       slot_rise;
	logic       wr_pend;
	logic       wr_q;
	logic [7:0] pend_data;
	logic       prg_d;
	logic       rom_base;
	logic       rom_store;

	always_comb begin
		dl_kind_o = c16_glue_pkg::NONE;
		if (ioctl_i.downloading) begin
			case (ioctl_i.index)
				c16_glue_pkg::IDX_ROM,
				c16_glue_pkg::IDX_KERNAL: dl_kind_o = c16_glue_pkg::ROM;
				c16_glue_pkg::IDX_PRG:    dl_kind_o = c16_glue_pkg::PRG;
				c16_glue_pkg::IDX_TAP:    dl_kind_o = c16_glue_pkg::TAP;
				default:                  dl_kind_o = c16_glue_pkg::NONE;
			endcase
		end
	end

	assign c16_wait_o = (dl_kind_o == c16_glue_pkg::ROM) || (dl_kind_o == c16_glue_pkg::PRG);

	assign slot_fall = last_clkref && !clkref_i;
	assign slot_rise = clkref_i && !last_clkref;

	// full images skip the 1541 part, kernal images start at zero
	assign rom_base = (ioctl_i.index == c16_glue_pkg::IDX_ROM &&
		ioctl_i.addr == c16_glue_pkg::KERNAL_ROM_OFFSET) ||
		(ioctl_i.index == c16_glue_pkg::IDX_KERNAL && ioctl_i.addr == '0);
	assign rom_store = (ioctl_i.index == c16_glue_pkg::IDX_ROM &&
		ioctl_i.addr[16:14] != 3'd0) ||
		ioctl_i.index == c16_glue_pkg::IDX_KERNAL;

	// ----------------------------------------------------------------------
	// sdram write during the io slot
	// ----------------------------------------------------------------------

	always_ff @(posedge clk28) begin
		last_clkref <= clkref_i;
		prg_d       <= (dl_kind_o == c16_glue_pkg::PRG);
		prg_done_o  <= prg_d && (dl_kind_o != c16_glue_pkg::PRG);

		if (slot_fall) begin
			wr_q    <= wr_pend;
			wr_pend <= 1'b0;
			if (wr_pend) begin
				io_wr_data_o <= pend_data;
			end
		end
		if (slot_rise) begin
			if (wr_q) begin
				io_wr_addr_o <= io_wr_addr_o + 25'd1;
			end
			wr_q <= 1'b0;
		end

		// a new byte waits here for the next io slot
		if (ioctl_i.wr) begin
			pend_data <= ioctl_i.data;
			case (dl_kind_o)
				c16_glue_pkg::PRG: begin
					// first two bytes hold the load address
					if (ioctl_i.addr == 25'd0) begin
						io_wr_addr_o[7:0] <= ioctl_i.data;
					end else if (ioctl_i.addr == 25'd1) begin
						io_wr_addr_o[24:8] <= {9'd0, ioctl_i.data};
					end else begin
						wr_pend <= 1'b1;
					end
				end
				c16_glue_pkg::TAP: begin
					if (ioctl_i.addr == 25'd0) begin
						io_wr_addr_o <= c16_glue_pkg::TAP_MEM_START;
					end
					wr_pend <= 1'b1;
				end
				c16_glue_pkg::ROM: begin
					if (rom_base) begin
						io_wr_addr_o <= c16_glue_pkg::ROM_MEM_START;
					end
					if (rom_store) begin
						wr_pend <= 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	assign io_wr_o = wr_q && !clkref_i;

	// ----------------------------------------------------------------------
	// rom load port of the core
	// ----------------------------------------------------------------------

	always_ff @(posedge clk28) begin
		rom_dl_o.kernal_wr <= 1'b0;
		rom_dl_o.basic_wr  <= 1'b0;
		if (ioctl_i.wr && dl_kind_o == c16_glue_pkg::ROM) begin
			rom_dl_o.addr      <= ioctl_i.addr[13:0];
			rom_dl_o.data      <= ioctl_i.data;
			rom_dl_o.kernal_wr <= ioctl_i.addr[16:14] == 3'd1 ||
				ioctl_i.index == c16_glue_pkg::IDX_KERNAL;
			rom_dl_o.basic_wr  <= ioctl_i.addr[16:14] == 3'd2 &&
				ioctl_i.index == c16_glue_pkg::IDX_ROM;
		end
	end

	assign rom_download_o = rom_dl_o.kernal_wr || rom_dl_o.basic_wr;

	a_byte_spacing: assert property (@(posedge clk28) ioctl_i.wr |-> !wr_pend)
		else $error("download byte arrived before the previous one was written");

endmodule

// File: verilog/zp_shadow.sv
`timescale 1ns/1ns

module zp_shadow (
	input  logic        clk28,
	input  logic [15:0] cpu_addr_i,
	input  logic        cpu_rw_i,
	input  logic [7:0]  cpu_dout_i,
	input  logic        rom_access_i,
	input  logic        cas_wr_stb_i,
	input  logic        prg_done_i,
	input  logic [15:0] end_addr_i,
	output logic        zp_hit_o,
	output logic [7:0]  zp_data_o
);

	logic [15:0] ptr [4];
	logic [3:0]  sel_lo;
	logic [3:0]  sel_hi;

	// address decode and overlay read mux
	always_comb begin
		zp_data_o = 8'hff;
		for (int i = 0; i < 4; i++) begin
			sel_lo[i] = (cpu_addr_i == c16_glue_pkg::ZP_END_PTR_ADDR[i]);
			sel_hi[i] = (cpu_addr_i == c16_glue_pkg::ZP_END_PTR_ADDR[i] + 16'd1);
			if (sel_lo[i]) begin
				zp_data_o = ptr[i][7:0];
			end
			if (sel_hi[i]) begin
				zp_data_o = ptr[i][15:8];
			end
		end
	end

	assign zp_hit_o = !rom_access_i && (|sel_lo || |sel_hi);

	always_ff @(posedge clk28) begin
		if (prg_done_i) begin
			// end of basic program is one past the last injected byte
			for (int i = 0; i < 4; i++) begin
				ptr[i] <= end_addr_i + 16'd1;
			end
		end else if (cas_wr_stb_i && !cpu_rw_i) begin
			for (int i = 0; i < 4; i++) begin
				if (sel_lo[i]) begin
					ptr[i][7:0] <= cpu_dout_i;
				end
				if (sel_hi[i]) begin
					ptr[i][15:8] <= cpu_dout_i;
				end
			end
		end
	end

	a_dl_priority: assert property (@(posedge clk28)
		prg_done_i |-> !(cas_wr_stb_i && !cpu_rw_i && (|sel_lo || |sel_hi)))
		else $error("cpu write to an end pointer lost to the prg patch");

endmodule

// File: verilog/sdram_arbiter.sv
`timescale 1ns/1ns

module sdram_arbiter (
	input  logic                                  clk28,
	input  logic                                  clkref_i,
	input  c16_glue_pkg::osd_cfg_t                cfg_i,
	input  c16_glue_pkg::c16_bus_t                c16_bus_i,
	input  logic [15:0]                           cpu_addr_i,
	input  logic                                  io_wr_i,
	input  logic [c16_glue_pkg::IOCTL_ADDR_W-1:0] io_wr_addr_i,
	input  logic [7:0]                            io_wr_data_i,
	input  c16_glue_pkg::dl_kind_t                dl_kind_i,
	input  logic                                  zp_hit_i,
	input  logic [7:0]                            zp_data_i,
	input  logic [15:0]                           sdram_dout_i,
	output c16_glue_pkg::sdram_req_t              sdram_req_o,
	output logic [7:0]                            c16_din_o,
	output logic                                  rom_access_o
);

	logic [1:0]  rom_bank;
	logic [15:0] ram_byte;
	logic [14:0] ram_word;
	logic        byte_hi;
	c16_glue_pkg::sdram_req_t req;

	assign rom_access_o = (!c16_bus_i.basic_sel || !c16_bus_i.kernal_sel) && c16_bus_i.rw;

	always_comb begin
		casez ({c16_bus_i.basic_sel, c16_bus_i.rom_sel})
			5'b1_00??: rom_bank = 2'd0;
			5'b0_??00: rom_bank = 2'd1;
			5'b0_??10: rom_bank = 2'd2;
			5'b1_10??: rom_bank = 2'd3;
			// cartridge banks are not backed by sdram
			default:   rom_bank = 2'd0;
		endcase
	end

	// prg bytes go through the same ram map as the cpu
	assign ram_byte = clkref_i ? cpu_addr_i : io_wr_addr_i[15:0];
	assign ram_word = cfg_i.memory_16k ?
		{1'b0, ram_byte[13:7], 1'b0, ram_byte[6:1]} : ram_byte[15:1];

	always_comb begin
		req     = '0;
		byte_hi = io_wr_addr_i[0];
		if (clkref_i) begin
			if (rom_access_o) begin
				req.addr = {8'd0, 1'b1, rom_bank, c16_bus_i.rom_addr[13:1]};
				byte_hi  = c16_bus_i.rom_addr[0];
			end else begin
				req.addr = {9'd0, ram_word};
				byte_hi  = cpu_addr_i[0];
			end
			req.din = {c16_bus_i.dout, c16_bus_i.dout};
			req.we  = !c16_bus_i.cas && !c16_bus_i.rw;
			req.oe  = (!c16_bus_i.cas && c16_bus_i.rw) || rom_access_o;
		end else begin
			if (dl_kind_i == c16_glue_pkg::PRG) begin
				req.addr = {9'd0, ram_word};
			end else begin
				req.addr = io_wr_addr_i[24:1];
			end
			req.din = {io_wr_data_i, io_wr_data_i};
			req.we  = io_wr_i;
		end
		req.ds = {byte_hi, !byte_hi};
	end

	always_ff @(posedge clk28) begin
		sdram_req_o <= req;
	end

	assign c16_din_o = zp_hit_i ? zp_data_i :
		(cpu_addr_i[0] ? sdram_dout_i[15:8] : sdram_dout_i[7:0]);

endmodule

// File: verilog/c16_glue_top.sv
`timescale 1ns/1ns

module c16_glue_top #(
	parameter int unsigned LONG_CYCLES  = c16_glue_pkg::RESET_LONG_CYCLES,
	parameter int unsigned SHORT_CYCLES = c16_glue_pkg::RESET_SHORT_CYCLES
) (
	input  logic                     clk28,
	input  logic                     pll_locked,
	input  c16_glue_pkg::c16_bus_t   c16_bus_i,
	input  c16_glue_pkg::ioctl_t     ioctl_i,
	input  logic [31:0]              status_i,
	input  logic                     button_reset_i,
	input  logic [15:0]              sdram_dout_i,
	output c16_glue_pkg::sdram_req_t sdram_req_o,
	output logic [7:0]               c16_din_o,
	output logic                     c16_reset_o,
	output logic                     c16_wait_o,
	output c16_glue_pkg::rom_dl_t    rom_dl_o,
	output logic [1:0]               sid_type_o
);

	c16_glue_pkg::osd_cfg_t cfg;
	logic long_req;
	logic short_req;
	logic rom_download_stb;

	logic        clkref;
	logic [15:0] cpu_addr;
	logic        cas_wr_stb;

	c16_glue_pkg::dl_kind_t dl_kind;
	logic                                  io_wr;
	logic [c16_glue_pkg::IOCTL_ADDR_W-1:0] io_wr_addr;
	logic [7:0]                            io_wr_data;
	logic                                  prg_done;

	logic       zp_hit;
	logic [7:0] zp_data;
	logic       rom_access;

	assign sid_type_o = cfg.sid_type;

	// ----------------------------------------------------------------------
	// menu settings and reset
	// ----------------------------------------------------------------------

	osd_config u_osd_config (
		.clk28          (clk28),
		.pll_locked     (pll_locked),
		.status_i       (status_i),
		.button_reset_i (button_reset_i),
		.cfg_o          (cfg),
		.long_req_o     (long_req),
		.short_req_o    (short_req)
	);

	reset_ctrl #(
		.LONG_CYCLES  (LONG_CYCLES),
		.SHORT_CYCLES (SHORT_CYCLES)
	) u_reset_ctrl (
		.clk28          (clk28),
		.pll_locked     (pll_locked),
		.long_req_i     (long_req),
		.short_req_i    (short_req),
		.rom_download_i (rom_download_stb),
		.reset_o        (c16_reset_o)
	);

	// ----------------------------------------------------------------------
	// memory path
	// ----------------------------------------------------------------------

	bus_phase u_bus_phase (
		.clk28        (clk28),
		.c16_bus_i    (c16_bus_i),
		.clkref_o     (clkref),
		.cpu_addr_o   (cpu_addr),
		.cas_wr_stb_o (cas_wr_stb)
	);

	download_injector u_download_injector (
		.clk28          (clk28),
		.ioctl_i        (ioctl_i),
		.clkref_i       (clkref),
		.dl_kind_o      (dl_kind),
		.io_wr_o        (io_wr),
		.io_wr_addr_o   (io_wr_addr),
		.io_wr_data_o   (io_wr_data),
		.prg_done_o     (prg_done),
		.rom_download_o (rom_download_stb),
		.rom_dl_o       (rom_dl_o),
		.c16_wait_o     (c16_wait_o)
	);

	zp_shadow u_zp_shadow (
		.clk28        (clk28),
		.cpu_addr_i   (cpu_addr),
		.cpu_rw_i     (c16_bus_i.rw),
		.cpu_dout_i   (c16_bus_i.dout),
		.rom_access_i (rom_access),
		.cas_wr_stb_i (cas_wr_stb),
		.prg_done_i   (prg_done),
		// write pointer has already moved past the last prg byte
		.end_addr_i   (io_wr_addr[15:0] - 16'd1),
		.zp_hit_o     (zp_hit),
		.zp_data_o    (zp_data)
	);

	sdram_arbiter u_sdram_arbiter (
		.clk28        (clk28),
		.clkref_i     (clkref),
		.cfg_i        (cfg),
		.c16_bus_i    (c16_bus_i),
		.cpu_addr_i   (cpu_addr),
		.io_wr_i      (io_wr),
		.io_wr_addr_i (io_wr_addr),
		.io_wr_data_i (io_wr_data),
		.dl_kind_i    (dl_kind),
		.zp_hit_i     (zp_hit),
		.zp_data_i    (zp_data),
		.sdram_dout_i (sdram_dout_i),
		.sdram_req_o  (sdram_req_o),
		.c16_din_o    (c16_din_o),
		.rom_access_o (rom_access)
	);

endmodule

// File: include/c16_glue_tb_tasks.svh
`ifndef C16_GLUE_TB_TASKS_SVH
`define C16_GLUE_TB_TASKS_SVH

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		fail_run($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
	end
endtask

task automatic check_sdram_req(input string name, input c16_glue_pkg::sdram_req_t got,
	input c16_glue_pkg::sdram_req_t exp);
	if (got !== exp) begin
		fail_run($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
	end
endtask

task automatic check_rom_dl(input string name, input c16_glue_pkg::rom_dl_t got,
	input c16_glue_pkg::rom_dl_t exp);
	if (got !== exp) begin
		fail_run($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
	end
endtask

// ----------------------------------------------------------------------
// drivers and waits
// ----------------------------------------------------------------------

// one-cycle write strobe from the io controller
task automatic send_ioctl_byte(input logic [24:0] addr, input logic [7:0] data);
	@(posedge clk28);
	ioctl.wr   <= 1'b1;
	ioctl.addr <= addr;
	ioctl.data <= data;
	@(posedge clk28);
	ioctl.wr <= 1'b0;
endtask

// first cycle of an sdram write, then wait until the io slot is over
task automatic wait_sdram_write(output c16_glue_pkg::sdram_req_t req);
	int n;
	n = 0;
	while (sdram_req_o.we !== 1'b1) begin
		@(negedge clk28);
		n++;
		if (n > 64) fail_run("timeout: no sdram write for the download byte");
	end
	req = sdram_req_o;
	n = 0;
	while (sdram_req_o.we !== 1'b0) begin
		@(negedge clk28);
		n++;
		if (n > 32) fail_run("timeout: sdram write did not end with the io slot");
	end
	repeat (4) @(posedge clk28);
endtask

// ras then cas fall, hold until the c16 slot issues the read
task automatic cpu_read(input logic [15:0] addr, input logic rom,
	output c16_glue_pkg::sdram_req_t req, output logic [7:0] din);
	int n;
	@(posedge clk28);
	c16_bus.a         <= addr[7:0];
	c16_bus.ras       <= 1'b0;
	c16_bus.rw        <= 1'b1;
	c16_bus.basic_sel <= !rom;
	c16_bus.rom_addr  <= addr[13:0];
	@(posedge clk28);
	c16_bus.a   <= addr[15:8];
	c16_bus.cas <= 1'b0;
	n = 0;
	do begin
		@(negedge clk28);
		n++;
		if (n > 40) fail_run("timeout: cpu read got no sdram read request");
	end while (sdram_req_o.oe !== 1'b1);
	req = sdram_req_o;
	din = c16_din_o;
	@(posedge clk28);
	c16_bus.ras       <= 1'b1;
	c16_bus.cas       <= 1'b1;
	c16_bus.basic_sel <= 1'b1;
endtask

task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
	int n;
	@(posedge clk28);
	c16_bus.a    <= addr[7:0];
	c16_bus.ras  <= 1'b0;
	c16_bus.rw   <= 1'b0;
	c16_bus.dout <= data;
	@(posedge clk28);
	c16_bus.a   <= addr[15:8];
	c16_bus.cas <= 1'b0;
	n = 0;
	do begin
		@(negedge clk28);
		n++;
		if (n > 40) fail_run("timeout: cpu write got no sdram write request");
	end while (sdram_req_o.we !== 1'b1);
	@(posedge clk28);
	c16_bus.ras  <= 1'b1;
	c16_bus.cas  <= 1'b1;
	c16_bus.rw   <= 1'b1;
	c16_bus.dout <= 8'h00;
endtask

task automatic wait_reset_high(input string why);
	int n;
	n = 0;
	while (c16_reset_o !== 1'b1) begin
		@(negedge clk28);
		n++;
		if (n > 8) fail_run({"timeout: core reset not raised after ", why});
	end
endtask

// count cycles until the core leaves reset
task automatic measure_reset(input int exp, input int tol, input string why);
	int n;
	n = 0;
	while (c16_reset_o !== 1'b0) begin
		@(negedge clk28);
		n++;
		if (n > exp + tol) fail_run({"timeout: core reset stuck high after ", why});
	end
	if (n < exp - tol) begin
		fail_run($sformatf("[ERROR] c16_reset_o: low after %h cycles expected %h", n, exp));
	end
endtask

`endif

// File: verif/c16_glue_tb.sv
`timescale 1ns/1ns

module c16_glue_tb;

	logic                     clk28;
	logic                     pll_locked;
	c16_glue_pkg::c16_bus_t   c16_bus;
	c16_glue_pkg::ioctl_t     ioctl;
	logic [31:0]              status;
	logic                     button_reset;
	logic [15:0]              sdram_dout;
	c16_glue_pkg::sdram_req_t sdram_req_o;
	logic [7:0]               c16_din_o;
	logic                     c16_reset_o;
	logic                     c16_wait_o;
	c16_glue_pkg::rom_dl_t    rom_dl_o;
	logic [1:0]               sid_type_o;
	int                       seed;

	c16_glue_top #(.LONG_CYCLES(200), .SHORT_CYCLES(50)) UUT (
		.clk28          (clk28),
		.pll_locked     (pll_locked),
		.c16_bus_i      (c16_bus),
		.ioctl_i        (ioctl),
		.status_i       (status),
		.button_reset_i (button_reset),
		.sdram_dout_i   (sdram_dout),
		.sdram_req_o    (sdram_req_o),
		.c16_din_o      (c16_din_o),
		.c16_reset_o    (c16_reset_o),
		.c16_wait_o     (c16_wait_o),
		.rom_dl_o       (rom_dl_o),
		.sid_type_o     (sid_type_o)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	`include "c16_glue_tb_tasks.svh"

	// expected io slot write for one byte
	function automatic c16_glue_pkg::sdram_req_t write_req(input logic [24:0] byte_addr,
		input logic [7:0] data);
		c16_glue_pkg::sdram_req_t r;
		r      = '0;
		r.addr = byte_addr[24:1];
		r.din  = {data, data};
		r.we   = 1'b1;
		r.ds   = {byte_addr[0], !byte_addr[0]};
		return r;
	endfunction

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------

	task automatic time_resets();
		measure_reset(200, 16, "power up");
		@(posedge clk28);
		status <= 32'h10;
		wait_reset_high("16k switch");
		measure_reset(50, 16, "16k switch");
		@(posedge clk28);
		status <= 32'h0;
		wait_reset_high("64k switch");
		measure_reset(50, 16, "64k switch");
		@(posedge clk28);
		button_reset <= 1'b1;
		@(posedge clk28);
		button_reset <= 1'b0;
		wait_reset_high("button");
		measure_reset(50, 16, "button");
	endtask

	task automatic download_rom();
		c16_glue_pkg::rom_dl_t    exp_dl;
		c16_glue_pkg::sdram_req_t req;
		logic [7:0]               d;
		@(posedge clk28);
		ioctl.downloading <= 1'b1;
		ioctl.index       <= c16_glue_pkg::IDX_ROM;
		d = $random(seed);
		send_ioctl_byte(25'h4000, d);
		@(negedge clk28);
		exp_dl = '{addr: 14'h0, data: d, kernal_wr: 1'b1, basic_wr: 1'b0};
		check_rom_dl("rom_dl_o kernal", rom_dl_o, exp_dl);
		wait_sdram_write(req);
		check_sdram_req("sdram_req_o rom", req, write_req(c16_glue_pkg::ROM_MEM_START, d));
		d = $random(seed);
		send_ioctl_byte(25'h8000, d);
		@(negedge clk28);
		exp_dl = '{addr: 14'h0, data: d, kernal_wr: 1'b0, basic_wr: 1'b1};
		check_rom_dl("rom_dl_o basic", rom_dl_o, exp_dl);
		wait_sdram_write(req);
		@(posedge clk28);
		ioctl.downloading <= 1'b0;
	endtask

	task automatic inject_prg();
		c16_glue_pkg::sdram_req_t req;
		logic [7:0]               d;
		@(posedge clk28);
		ioctl.downloading <= 1'b1;
		ioctl.index       <= c16_glue_pkg::IDX_PRG;
		send_ioctl_byte(25'd0, 8'h01);
		send_ioctl_byte(25'd1, 8'h10);
		@(negedge clk28);
		check_byte("c16_wait_o", {7'd0, c16_wait_o}, 8'h01);
		for (int i = 0; i < 3; i++) begin
			d = $random(seed);
			send_ioctl_byte(25'd2 + i, d);
			wait_sdram_write(req);
			check_sdram_req("sdram_req_o prg", req, write_req(25'h1001 + i, d));
		end
		@(posedge clk28);
		ioctl.downloading <= 1'b0;
		repeat (4) @(posedge clk28);
	endtask

	task automatic read_zero_page();
		c16_glue_pkg::sdram_req_t req;
		logic [7:0]               din;
		logic [15:0]              end_ptr;
		// three bytes from 0x1001 leave basic ending at 0x1004
		end_ptr = 16'h1004;
		for (int i = 0; i < 4; i++) begin
			cpu_read(c16_glue_pkg::ZP_END_PTR_ADDR[i], 1'b0, req, din);
			check_byte("c16_din_o zp low", din, end_ptr[7:0]);
			cpu_read(c16_glue_pkg::ZP_END_PTR_ADDR[i] + 16'd1, 1'b0, req, din);
			check_byte("c16_din_o zp high", din, end_ptr[15:8]);
		end
		cpu_write(16'h002d, 8'h55);
		cpu_read(16'h002d, 1'b0, req, din);
		check_byte("c16_din_o zp write", din, 8'h55);
	endtask

	task automatic map_reads();
		c16_glue_pkg::sdram_req_t req;
		c16_glue_pkg::sdram_req_t exp;
		logic [7:0]               din;
		logic [15:0]              a;
		@(posedge clk28);
		sdram_dout <= 16'ha55a;
		a = 16'h1235;
		cpu_read(a, 1'b0, req, din);
		check_byte("c16_din_o ram", din, 8'ha5);
		exp = '{addr: {9'd0, a[15:1]}, din: 16'h0, we: 1'b0, oe: 1'b1, ds: 2'b10};
		check_sdram_req("sdram_req_o ram 64k", req, exp);
		// basic rom is bank 1 inside the rom region
		cpu_read(a, 1'b1, req, din);
		exp = '{addr: {8'd0, 1'b1, 2'd1, a[13:1]}, din: 16'h0, we: 1'b0, oe: 1'b1, ds: 2'b10};
		check_sdram_req("sdram_req_o basic", req, exp);
		// sid type sits in bits 9..8 of the status word
		@(posedge clk28);
		status <= 32'h210;
		repeat (3) @(posedge clk28);
		check_byte("sid_type_o", {6'd0, sid_type_o}, 8'h02);
		a = 16'h3f02;
		cpu_read(a, 1'b0, req, din);
		exp = '{addr: {9'd0, 1'b0, a[13:7], 1'b0, a[6:1]}, din: 16'h0, we: 1'b0, oe: 1'b1,
			ds: 2'b01};
		check_sdram_req("sdram_req_o ram 16k", req, exp);
		@(posedge clk28);
		status <= 32'h0;
	endtask

	task automatic store_tap();
		c16_glue_pkg::sdram_req_t req;
		logic [7:0]               d;
		@(posedge clk28);
		ioctl.downloading <= 1'b1;
		ioctl.index       <= c16_glue_pkg::IDX_TAP;
		for (int i = 0; i < 3; i++) begin
			d = $random(seed);
			send_ioctl_byte(25'd0 + i, d);
			wait_sdram_write(req);
			check_sdram_req("sdram_req_o tap", req,
				write_req(c16_glue_pkg::TAP_MEM_START + i, d));
		end
		@(posedge clk28);
		ioctl.downloading <= 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// clock and sequence
	// ----------------------------------------------------------------------

	initial begin
		clk28 = 1'b0;
		forever #4 clk28 = !clk28;
	end

	initial begin
		seed         = 32'h4de73b91;
		pll_locked   = 1'b0;
		c16_bus      = '0;
		c16_bus.ras  = 1'b1;
		c16_bus.cas  = 1'b1;
		c16_bus.rw   = 1'b1;
		c16_bus.basic_sel  = 1'b1;
		c16_bus.kernal_sel = 1'b1;
		ioctl        = '0;
		status       = 32'h0;
		button_reset = 1'b0;
		sdram_dout   = 16'h0;
		// one row strobe starts the slot divider
		repeat (3) @(posedge clk28);
		c16_bus.ras <= 1'b0;
		@(posedge clk28);
		c16_bus.ras <= 1'b1;
		repeat (4) @(posedge clk28);
		pll_locked <= 1'b1;
		time_resets();
		download_rom();
		inject_prg();
		read_zero_page();
		map_reads();
		store_tap();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: c16_glue.f
verilog/c16_glue_pkg.sv
verilog/osd_config.sv
verilog/reset_ctrl.sv
verilog/bus_phase.sv
verilog/download_injector.sv
verilog/zp_shadow.sv
verilog/sdram_arbiter.sv
verilog/c16_glue_top.sv
+incdir+include
verif/c16_glue_tb.sv
